//--- logic/isaPkg.sv
package isaPkg;

	// Datapath widths
	localparam int dataW = 8;
	localparam int addrW = 16;

	// Z80/GB encodings of the supported instructions
	typedef enum logic [7:0] {
		opNop    = 8'h00,
		opIncB   = 8'h04,
		opDecB   = 8'h05,
		opLdBN   = 8'h06,
		opLdCN   = 8'h0E,
		opJr     = 8'h18,
		opJrNz   = 8'h20,
		opLdHlNn = 8'h21,
		opLdHN   = 8'h26,
		opLdLN   = 8'h2E,
		opIncA   = 8'h3C,
		opLdAN   = 8'h3E,
		opLdBA   = 8'h47,
		opLdHlA  = 8'h77,
		opLdAHl  = 8'h7E,
		opLdAB   = 8'h78,
		opAddAB  = 8'h80,
		opSubB   = 8'h90,
		opXorN   = 8'hEE
	} opcodeT;

	// Operand selector carried by each micro-op
	typedef enum logic [3:0] {
		A, B, C, H, L, HL, PC, X8, MEM
	} regIdT;

endpackage

//--- logic/ucodePkg.sv
package ucodePkg;

	// Micro-program address width
	localparam int flowIdxW = 7;

	// Sequencing part of a micro-op
	typedef enum logic [2:0] {
		next,
		incPc,
		eof,
		incPcEof,
		incPcEofIfNz    // always steps PC, ends the flow only when Z is set
	} seqOpT;

	// Datapath action of a micro-op
	typedef enum logic [2:0] {
		nop,
		setAddr,
		memWrite,
		loadMem,
		copyToX8,
		copyFromX8,
		aluOp,
		jumpRel
	} actT;

	typedef enum logic [2:0] {
		add,
		sub,
		xorOp,
		inc,
		dec,
		pass
	} aluOpT;

	typedef struct packed {
		seqOpT         seq;
		actT           act;
		aluOpT         alu;
		isaPkg::regIdT operand;
		logic          updZ;
	} uopT;

	// What the datapath sees of the current micro-op
	typedef struct packed {
		actT           act;
		aluOpT         alu;
		isaPkg::regIdT operand;
		logic          updZ;
		logic          valid;
	} ctrlT;

	typedef struct packed {
		logic [isaPkg::addrW-1:0] addr;
		logic [isaPkg::dataW-1:0] wrData;
		logic                     rd;
		logic                     wr;
	} memReqT;

endpackage

//--- logic/ucodeRom.sv
`timescale 1ns/1ps

module ucodeRom
(
	input  isaPkg::opcodeT                opcode,
	input  logic [ucodePkg::flowIdxW-1:0] upc,
	output logic [ucodePkg::flowIdxW-1:0] flowStart,
	output ucodePkg::uopT                 uop
);
	import isaPkg::*;
	import ucodePkg::*;

	//////////////////////////////////////////////////////////////////////
	// Opcode to flow start
	//////////////////////////////////////////////////////////////////////
	always_comb
	begin
		case (opcode)
			opLdBN:   flowStart = 7'd1;
			opLdCN:   flowStart = 7'd5;
			opLdAN:   flowStart = 7'd9;
			opLdHN:   flowStart = 7'd13;
			opLdLN:   flowStart = 7'd17;
			opLdHlNn: flowStart = 7'd21;
			opLdHlA:  flowStart = 7'd28;
			opLdAHl:  flowStart = 7'd30;
			opLdAB:   flowStart = 7'd33;
			opLdBA:   flowStart = 7'd35;
			opAddAB:  flowStart = 7'd37;
			opSubB:   flowStart = 7'd38;
			opXorN:   flowStart = 7'd39;
			opIncB:   flowStart = 7'd44;
			opDecB:   flowStart = 7'd45;
			opJr:     flowStart = 7'd46;
			opJrNz:   flowStart = 7'd51;
			opIncA:   flowStart = 7'd56;
			// NOP and every unlisted byte
			default:  flowStart = 7'd0;
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// Flow table, fields are seq, act, alu, operand, updZ
	//////////////////////////////////////////////////////////////////////
	always_comb
	begin
		case (upc)
			// NOP
			7'd0:  uop = '{incPcEof,     nop,        pass,  A,  1'b0};
			// LD r,n for B, C, A, H and L
			7'd1:  uop = '{incPc,        nop,        pass,  A,  1'b0};
			7'd2:  uop = '{next,         setAddr,    pass,  PC, 1'b0};
			7'd3:  uop = '{next,         nop,        pass,  A,  1'b0};
			7'd4:  uop = '{incPcEof,     loadMem,    pass,  B,  1'b0};
			7'd5:  uop = '{incPc,        nop,        pass,  A,  1'b0};
			7'd6:  uop = '{next,         setAddr,    pass,  PC, 1'b0};
			7'd7:  uop = '{next,         nop,        pass,  A,  1'b0};
			7'd8:  uop = '{incPcEof,     loadMem,    pass,  C,  1'b0};
			7'd9:  uop = '{incPc,        nop,        pass,  A,  1'b0};
			7'd10: uop = '{next,         setAddr,    pass,  PC, 1'b0};
			7'd11: uop = '{next,         nop,        pass,  A,  1'b0};
			7'd12: uop = '{incPcEof,     loadMem,    pass,  A,  1'b0};
			7'd13: uop = '{incPc,        nop,        pass,  A,  1'b0};
			7'd14: uop = '{next,         setAddr,    pass,  PC, 1'b0};
			7'd15: uop = '{next,         nop,        pass,  A,  1'b0};
			7'd16: uop = '{incPcEof,     loadMem,    pass,  H,  1'b0};
			7'd17: uop = '{incPc,        nop,        pass,  A,  1'b0};
			7'd18: uop = '{next,         setAddr,    pass,  PC, 1'b0};
			7'd19: uop = '{next,         nop,        pass,  A,  1'b0};
			7'd20: uop = '{incPcEof,     loadMem,    pass,  L,  1'b0};
			// LD HL,nn low byte first
			7'd21: uop = '{incPc,        nop,        pass,  A,  1'b0};
			7'd22: uop = '{next,         setAddr,    pass,  PC, 1'b0};
			7'd23: uop = '{next,         nop,        pass,  A,  1'b0};
			7'd24: uop = '{incPc,        loadMem,    pass,  L,  1'b0};
			7'd25: uop = '{next,         setAddr,    pass,  PC, 1'b0};
			7'd26: uop = '{next,         nop,        pass,  A,  1'b0};
			7'd27: uop = '{incPcEof,     loadMem,    pass,  H,  1'b0};
			// LD (HL),A
			7'd28: uop = '{incPc,        setAddr,    pass,  HL, 1'b0};
			7'd29: uop = '{eof,          memWrite,   pass,  A,  1'b0};
			// LD A,(HL)
			7'd30: uop = '{incPc,        setAddr,    pass,  HL, 1'b0};
			7'd31: uop = '{next,         nop,        pass,  A,  1'b0};
			7'd32: uop = '{eof,          loadMem,    pass,  A,  1'b0};
			// Register moves through X8
			7'd33: uop = '{next,         copyToX8,   pass,  B,  1'b0};
			7'd34: uop = '{incPcEof,     copyFromX8, pass,  A,  1'b0};
			7'd35: uop = '{next,         copyToX8,   pass,  A,  1'b0};
			7'd36: uop = '{incPcEof,     copyFromX8, pass,  B,  1'b0};
			// ADD A,B and SUB B
			7'd37: uop = '{incPcEof,     aluOp,      add,   B,  1'b1};
			7'd38: uop = '{incPcEof,     aluOp,      sub,   B,  1'b1};
			// XOR n
			7'd39: uop = '{incPc,        nop,        pass,  A,  1'b0};
			7'd40: uop = '{next,         setAddr,    pass,  PC, 1'b0};
			7'd41: uop = '{next,         nop,        pass,  A,  1'b0};
			7'd42: uop = '{incPc,        loadMem,    pass,  X8, 1'b0};
			7'd43: uop = '{eof,          aluOp,      xorOp, X8, 1'b1};
			// INC B and DEC B
			7'd44: uop = '{incPcEof,     aluOp,      inc,   B,  1'b1};
			7'd45: uop = '{incPcEof,     aluOp,      dec,   B,  1'b1};
			// JR n
			7'd46: uop = '{incPc,        nop,        pass,  A,  1'b0};
			7'd47: uop = '{next,         setAddr,    pass,  PC, 1'b0};
			7'd48: uop = '{next,         nop,        pass,  A,  1'b0};
			7'd49: uop = '{incPc,        loadMem,    pass,  X8, 1'b0};
			7'd50: uop = '{eof,          jumpRel,    pass,  PC, 1'b0};
			// JR NZ,n falls through here when Z is set
			7'd51: uop = '{incPc,        nop,        pass,  A,  1'b0};
			7'd52: uop = '{next,         setAddr,    pass,  PC, 1'b0};
			7'd53: uop = '{next,         nop,        pass,  A,  1'b0};
			7'd54: uop = '{incPcEofIfNz, loadMem,    pass,  X8, 1'b0};
			7'd55: uop = '{eof,          jumpRel,    pass,  PC, 1'b0};
			// INC A
			7'd56: uop = '{incPcEof,     aluOp,      inc,   A,  1'b1};
			default: uop = '{eof,        nop,        pass,  A,  1'b0};
		endcase
	end
endmodule

//--- logic/microSequencer.sv
`timescale 1ns/1ps

module microSequencer
(
	input  logic                          clk,
	input  logic                          arstN,
	input  ucodePkg::uopT                 uop,
	input  logic [ucodePkg::flowIdxW-1:0] flowStart,
	input  logic [isaPkg::dataW-1:0]      memRdData,
	input  logic                          zFlag,
	output isaPkg::opcodeT                opcode,
	output logic [ucodePkg::flowIdxW-1:0] upc,
	output ucodePkg::ctrlT                ctrl,
	output logic                          fetch,
	output logic                          pcInc
);
	import isaPkg::*;
	import ucodePkg::*;

	typedef enum logic [1:0] {fetchSt, waitSt, decodeSt, execSt} stateT;

	stateT  state;
	opcodeT opcodeQ;
	logic   endOfFlow;

	// Opcode byte sits on the read bus during decode
	assign opcode = (state == decodeSt) ? opcodeT'(memRdData) : opcodeQ;

	assign endOfFlow = (uop.seq == eof) || (uop.seq == incPcEof) ||
		((uop.seq == incPcEofIfNz) && zFlag);

	assign fetch = (state == fetchSt);
	assign pcInc = (state == execSt) && (uop.seq inside {incPc, incPcEof, incPcEofIfNz});

	assign ctrl = '{act: uop.act, alu: uop.alu, operand: uop.operand, updZ: uop.updZ,
		valid: (state == execSt)};

	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
		begin
			state   <= fetchSt;
			upc     <= '0;
			opcodeQ <= opNop;
		end
		else
		begin
			case (state)
				fetchSt:  state <= waitSt;
				waitSt:   state <= decodeSt;
				decodeSt:
				begin
					opcodeQ <= opcode;
					upc     <= flowStart;
					state   <= execSt;
				end
				default:
				begin
					if (endOfFlow)
						state <= fetchSt;
					else
						upc <= upc + 1'b1;
				end
			endcase
		end
	end
endmodule

//--- logic/regFile.sv
`timescale 1ns/1ps

module regFile
(
	input  logic                     clk,
	input  logic                     arstN,
	input  ucodePkg::ctrlT           ctrl,
	input  logic [isaPkg::dataW-1:0] memRdData,
	input  logic [isaPkg::dataW-1:0] aluResult,
	output logic [isaPkg::dataW-1:0] aVal,
	output logic [isaPkg::dataW-1:0] operandVal,
	output logic [isaPkg::addrW-1:0] hlVal,
	output logic [isaPkg::dataW-1:0] x8Val
);
	import isaPkg::*;
	import ucodePkg::*;

	logic [dataW-1:0] a, b, c, h, l, x8;
	logic             wrEn;
	regIdT            wrId;
	logic [dataW-1:0] wrVal;

	assign aVal  = a;
	assign hlVal = {h, l};
	assign x8Val = x8;

	always_comb
	begin
		case (ctrl.operand)
			A:       operandVal = a;
			B:       operandVal = b;
			C:       operandVal = c;
			H:       operandVal = h;
			L:       operandVal = l;
			X8:      operandVal = x8;
			default: operandVal = '0;
		endcase
	end

	// Write-back target and value
	always_comb
	begin
		wrEn  = 1'b0;
		wrId  = ctrl.operand;
		wrVal = memRdData;
		case (ctrl.act)
			loadMem: wrEn = ctrl.valid;
			copyToX8:
			begin
				wrEn  = ctrl.valid;
				wrId  = X8;
				wrVal = operandVal;
			end
			copyFromX8:
			begin
				wrEn  = ctrl.valid;
				wrVal = x8;
			end
			aluOp:
			begin
				// Inc and dec work in place and everything else lands in A
				wrEn  = ctrl.valid && (ctrl.alu != pass);
				wrVal = aluResult;
				if (!(ctrl.alu inside {inc, dec}))
					wrId = A;
			end
			default: ;
		endcase
	end

	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
		begin
			a  <= '0;
			b  <= '0;
			c  <= '0;
			h  <= '0;
			l  <= '0;
			x8 <= '0;
		end
		else if (wrEn)
		begin
			case (wrId)
				A:       a  <= wrVal;
				B:       b  <= wrVal;
				C:       c  <= wrVal;
				H:       h  <= wrVal;
				L:       l  <= wrVal;
				X8:      x8 <= wrVal;
				default: ;
			endcase
		end
	end
endmodule

//--- logic/alu.sv
`timescale 1ns/1ps

module alu
(
	input  logic                     clk,
	input  logic                     arstN,
	input  ucodePkg::ctrlT           ctrl,
	input  logic [isaPkg::dataW-1:0] aVal,
	input  logic [isaPkg::dataW-1:0] operandVal,
	output logic [isaPkg::dataW-1:0] aluResult,
	output logic                     zFlag
);
	import ucodePkg::*;

	// 8-bit results, add and sub wrap
	always_comb
	begin
		case (ctrl.alu)
			add:     aluResult = aVal + operandVal;
			sub:     aluResult = aVal - operandVal;
			xorOp:   aluResult = aVal ^ operandVal;
			inc:     aluResult = operandVal + 1'b1;
			dec:     aluResult = operandVal - 1'b1;
			default: aluResult = operandVal;
		endcase
	end

	// Only flag kept is Z
	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
			zFlag <= 1'b0;
		else if (ctrl.valid && (ctrl.act == aluOp) && ctrl.updZ)
			zFlag <= (aluResult == '0);
	end
endmodule

//--- logic/addrUnit.sv
`timescale 1ns/1ps

module addrUnit
(
	input  logic                     clk,
	input  logic                     arstN,
	input  ucodePkg::ctrlT           ctrl,
	input  logic                     fetch,
	input  logic                     pcInc,
	input  logic [isaPkg::addrW-1:0] hlVal,
	input  logic [isaPkg::dataW-1:0] x8Val,
	input  logic [isaPkg::dataW-1:0] operandVal,
	output ucodePkg::memReqT         memReq
);
	import isaPkg::*;
	import ucodePkg::*;

	logic [addrW-1:0] pc;
	logic [addrW-1:0] addrQ;
	logic [dataW-1:0] wrDataQ;
	logic             rdQ;
	logic             wrQ;
	logic             takeAddr;
	logic             takeWrite;
	logic             takeJump;

	assign takeAddr  = ctrl.valid && (ctrl.act == setAddr);
	assign takeWrite = ctrl.valid && (ctrl.act == memWrite);
	assign takeJump  = ctrl.valid && (ctrl.act == jumpRel);

	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
		begin
			pc  <= '0;
			rdQ <= 1'b0;
			wrQ <= 1'b0;
		end
		else
		begin
			rdQ <= fetch || takeAddr;
			wrQ <= takeWrite;
			// Offset counts from the byte after the offset
			if (takeJump)
				pc <= pc + {{(addrW - dataW){x8Val[dataW-1]}}, x8Val};
			else if (pcInc)
				pc <= pc + 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (fetch)
			addrQ <= pc;
		else if (takeAddr)
			addrQ <= (ctrl.operand == HL) ? hlVal : pc;
		if (takeWrite)
			wrDataQ <= operandVal;
	end

	assign memReq = '{addr: addrQ, wrData: wrDataQ, rd: rdQ, wr: wrQ};
endmodule

//--- logic/cpuTop.sv
`timescale 1ns/1ps

module cpuTop
(
	input  logic                     clk,
	input  logic                     arstN,
	output ucodePkg::memReqT         memReq,
	input  logic [isaPkg::dataW-1:0] memRdData
);
	import isaPkg::*;
	import ucodePkg::*;

	opcodeT              opcode;
	logic [flowIdxW-1:0] upc;
	logic [flowIdxW-1:0] flowStart;
	uopT                 uop;
	ctrlT                ctrl;
	logic                fetch;
	logic                pcInc;
	logic                zFlag;
	logic [dataW-1:0]    aVal;
	logic [dataW-1:0]    operandVal;
	logic [dataW-1:0]    aluResult;
	logic [dataW-1:0]    x8Val;
	logic [addrW-1:0]    hlVal;

	// Control
	microSequencer seq_i (.*);
	ucodeRom       rom_i (.*);

	// Datapath
	regFile  regs_i (.*);
	alu      alu_i  (.*);
	addrUnit addr_i (.*);
endmodule

//--- bench/cpuBus_assertions.sv
`timescale 1ns/1ps

module cpuBus_assertions
(
	input logic             clk,
	input logic             arstN,
	input ucodePkg::memReqT memReq
);
	// Failure count, read by the testbench summary
	int busErrors = 0;

	// Read and write never share a cycle
	rdWrExclusive: assert property (@(posedge clk) disable iff (!arstN)
		!(memReq.rd && memReq.wr))
	else
	begin
		$error("memReq.rd and memReq.wr are both high");
		busErrors++;
	end

	// Address must be known on any request
	addrKnown: assert property (@(posedge clk) disable iff (!arstN)
		(memReq.rd || memReq.wr) |-> !$isunknown(memReq.addr))
	else
	begin
		$error("memReq.addr has unknown bits during a request");
		busErrors++;
	end

	// Bus stays idle in reset
	idleInReset: assert property (@(posedge clk)
		!arstN |-> (!memReq.rd && !memReq.wr))
	else
	begin
		$error("memory request active while arstN is low");
		busErrors++;
	end
endmodule

//--- bench/cpuTb.sv
`timescale 1ns/1ps

module cpuTb;
	import isaPkg::*;
	import ucodePkg::*;

	localparam int clkPeriod   = 4;
	localparam int resetCycles = 8;
	localparam int maxCycles   = 400;
	localparam int numTests    = 6;
	localparam int watchdogNs  = numTests * (maxCycles + resetCycles + 2) * clkPeriod;

	logic             clk = 1'b0;
	logic             arstN = 1'b0;
	memReqT           memReq;
	logic [dataW-1:0] memRdData = '0;

	logic [7:0]  mem [256];
	logic [7:0]  prog [$];
	logic [15:0] wrAddrLog [$];
	logic [7:0]  wrDataLog [$];
	int          logStart = 0;
	int          checks = 0;
	int          errors = 0;
	int          busFails;
	integer      seed = 32'hae2e22b4;

	cpuTop dut_i (.clk(clk), .arstN(arstN), .memReq(memReq), .memRdData(memRdData));

	bind cpuTop cpuBus_assertions busChk_i (.clk(clk), .arstN(arstN), .memReq(memReq));

	always #(clkPeriod / 2) clk = ~clk;

	//////////////////////////////////////////////////////////////////////
	// Memory model
	//////////////////////////////////////////////////////////////////////

	// Data one cycle after rd, low address byte only
	always @(posedge clk)
	begin
		if (memReq.rd)
			memRdData <= mem[memReq.addr[7:0]];
	end

	// Every write goes to the log
	always @(posedge clk)
	begin
		if (arstN && memReq.wr)
		begin
			wrAddrLog.push_back(memReq.addr);
			wrDataLog.push_back(memReq.wrData);
		end
	end

	function automatic logic [7:0] fillByte(input int addr);
		return addr[7:0] ^ 8'hA5;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Program building and running
	//////////////////////////////////////////////////////////////////////
	task automatic emitOp(input logic [7:0] op);
		prog.push_back(op);
	endtask

	task automatic emitImm(input logic [7:0] op, input logic [7:0] n);
		prog.push_back(op);
		prog.push_back(n);
	endtask

	task automatic emitLdHl(input logic [15:0] nn);
		emitOp(opLdHlNn);
		emitOp(nn[7:0]);
		emitOp(nn[15:8]);
	endtask

	// Store A at 00FF, then spin on JR -2
	task automatic emitDoneMarker();
		emitLdHl(16'h00FF);
		emitOp(opLdHlA);
		emitImm(opJr, 8'hFE);
	endtask

	task automatic runProgram();
		bit found;
		int cycles;
		int i;
		@(posedge clk);
		arstN <= 1'b0;
		@(negedge clk);
		for (i = 0; i < 256; i++)
			mem[i] = (i < prog.size()) ? prog[i] : fillByte(i);
		logStart = wrAddrLog.size();
		repeat (resetCycles) @(posedge clk);
		arstN <= 1'b1;
		found = 1'b0;
		cycles = 0;
		while (!found && cycles < maxCycles)
		begin
			@(negedge clk);
			cycles++;
			for (i = logStart; i < wrAddrLog.size(); i++)
				if (wrAddrLog[i] == 16'h00FF)
					found = 1'b1;
		end
		checks++;
		assert (found)
		else
		begin
			$display("Timeout: no write to the done address within %0d cycles", maxCycles);
			errors++;
		end
	endtask

	task automatic expectWrite(input int n, input logic [15:0] addr, input logic [7:0] data);
		int idx;
		idx = logStart + n;
		checks++;
		assert (idx < wrAddrLog.size())
		else
		begin
			$display("Write number %0d to address %h never happened", n, addr);
			errors++;
		end
		if (idx < wrAddrLog.size())
		begin
			checks++;
			assert (wrAddrLog[idx] == addr)
			else
			begin
				$display("[ERROR] memReq.addr (write %0d): expected 0x%h, got 0x%h",
					n, addr, wrAddrLog[idx]);
				errors++;
			end
			checks++;
			assert (wrDataLog[idx] == data)
			else
			begin
				$display("[ERROR] memReq.wrData (write %0d): expected 0x%h, got 0x%h",
					n, data, wrDataLog[idx]);
				errors++;
			end
		end
	endtask

	task automatic expectWriteTotal(input int n);
		checks++;
		assert (wrAddrLog.size() - logStart == n)
		else
		begin
			$display("Expected %0d writes but saw %0d", n, wrAddrLog.size() - logStart);
			errors++;
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Directed tests
	//////////////////////////////////////////////////////////////////////
	task automatic loadAndStore();
		prog.delete();
		emitLdHl(16'h0040);
		emitImm(opLdAN, 8'h5A);
		emitOp(opLdHlA);
		emitDoneMarker();
		runProgram();
		expectWrite(0, 16'h0040, 8'h5A);
		expectWrite(1, 16'h00FF, 8'h5A);
		expectWriteTotal(2);
	endtask

	task automatic addSubWrap();
		logic [7:0] sum;
		logic [7:0] diff;
		// Both wrap at 256
		sum = 8'hF0 + 8'h20;
		diff = sum - 8'h20;
		prog.delete();
		emitLdHl(16'h0040);
		emitImm(opLdAN, 8'hF0);
		emitImm(opLdBN, 8'h20);
		emitOp(opAddAB);
		emitOp(opLdHlA);
		emitOp(opSubB);
		emitImm(opLdLN, 8'h41);
		emitOp(opLdHlA);
		emitDoneMarker();
		runProgram();
		expectWrite(0, 16'h0040, sum);
		expectWrite(1, 16'h0041, diff);
		expectWrite(2, 16'h00FF, diff);
		expectWriteTotal(3);
	endtask

	task automatic xorIncDec();
		logic [7:0] xorVal;
		logic [7:0] incVal;
		logic [7:0] decVal;
		xorVal = 8'h3C ^ 8'hA5;
		incVal = 8'h7F + 8'h01;
		decVal = incVal - 8'h02;
		prog.delete();
		emitImm(opLdHN, 8'h00);
		emitImm(opLdLN, 8'h40);
		emitImm(opLdAN, 8'h3C);
		emitImm(opXorN, 8'hA5);
		emitOp(opLdHlA);
		emitImm(opLdBN, 8'h7F);
		emitOp(opIncB);
		emitOp(opLdAB);
		emitImm(opLdLN, 8'h41);
		emitOp(opLdHlA);
		emitOp(opDecB);
		emitOp(opDecB);
		emitOp(opLdAB);
		emitImm(opLdLN, 8'h42);
		emitOp(opLdHlA);
		emitDoneMarker();
		runProgram();
		expectWrite(0, 16'h0040, xorVal);
		expectWrite(1, 16'h0041, incVal);
		expectWrite(2, 16'h0042, decVal);
		expectWrite(3, 16'h00FF, decVal);
		expectWriteTotal(4);
	endtask

	task automatic jrNzLoop();
		logic [7:0] count;
		int loopStart;
		count = 8'h05;
		prog.delete();
		emitImm(opLdBN, count);
		emitImm(opLdAN, 8'h00);
		loopStart = prog.size();
		emitOp(opIncA);
		emitOp(opDecB);
		// Offset counts from the byte after itself
		emitImm(opJrNz, 8'(loopStart - (prog.size() + 2)));
		emitLdHl(16'h0040);
		emitOp(opLdHlA);
		emitDoneMarker();
		runProgram();
		expectWrite(0, 16'h0040, count);
		expectWrite(1, 16'h00FF, count);
		expectWriteTotal(2);
	endtask

	task automatic memReadAndJump();
		logic [7:0] loaded;
		loaded = fillByte(8'h80);
		prog.delete();
		emitLdHl(16'h0080);
		emitOp(opLdAHl);
		emitOp(opLdBA);
		emitImm(opLdAN, 8'h00);
		emitOp(opLdAB);
		emitImm(opLdLN, 8'h41);
		emitOp(opLdHlA);
		// Skips the poisoned store
		emitImm(opJr, 8'h01);
		emitOp(opLdHlA);
		// Unlisted opcode runs as NOP
		emitOp(8'hD3);
		emitOp(opNop);
		emitImm(opLdCN, 8'h33);
		emitImm(opLdLN, 8'h42);
		emitOp(opLdHlA);
		emitDoneMarker();
		runProgram();
		expectWrite(0, 16'h0041, loaded);
		expectWrite(1, 16'h0042, loaded);
		expectWrite(2, 16'h00FF, loaded);
		expectWriteTotal(3);
	endtask

	task automatic randomAddSub();
		logic [7:0] av [4];
		logic [7:0] bv [4];
		int k;
		prog.delete();
		emitImm(opLdHN, 8'h00);
		for (k = 0; k < 4; k++)
		begin
			av[k] = 8'($random(seed));
			bv[k] = 8'($random(seed));
			emitImm(opLdLN, 8'(8'h40 + 2 * k));
			emitImm(opLdAN, av[k]);
			emitImm(opLdBN, bv[k]);
			emitOp(opAddAB);
			emitOp(opLdHlA);
			emitImm(opLdLN, 8'(8'h41 + 2 * k));
			emitImm(opLdAN, av[k]);
			emitOp(opSubB);
			emitOp(opLdHlA);
		end
		emitDoneMarker();
		runProgram();
		for (k = 0; k < 4; k++)
		begin
			expectWrite(2 * k, 16'(16'h0040 + 2 * k), 8'(av[k] + bv[k]));
			expectWrite(2 * k + 1, 16'(16'h0041 + 2 * k), 8'(av[k] - bv[k]));
		end
		expectWrite(8, 16'h00FF, 8'(av[3] - bv[3]));
		expectWriteTotal(9);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Sequence, watchdog and summary
	//////////////////////////////////////////////////////////////////////
	initial
	begin
		loadAndStore();
		addSubWrap();
		xorIncDec();
		jrNzLoop();
		memReadAndJump();
		randomAddSub();
		busFails = dut_i.busChk_i.busErrors;
		$display("Checks: %0d, errors: %0d, bus assertion failures: %0d",
			checks, errors, busFails);
		if (errors == 0 && busFails == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

	initial
	begin
		#(watchdogNs);
		$display("Watchdog expired after %0d ns before the tests finished", watchdogNs);
		$display("Test failed");
		$finish;
	end
endmodule

//--- sim.f
logic/isaPkg.sv
logic/ucodePkg.sv
logic/ucodeRom.sv
logic/microSequencer.sv
logic/regFile.sv
logic/alu.sv
logic/addrUnit.sv
logic/cpuTop.sv
bench/cpuBus_assertions.sv
bench/cpuTb.sv

//--- Makefile
TOP = cpuTb

all: run

run:
	verilator --binary --assert -Wno-fatal --top-module $(TOP) -f sim.f -o $(TOP)
	./obj_dir/$(TOP) +verilator+error+limit+100 | tee sim.log
	@if grep -q "Test failed" sim.log; then echo "Simulation reported failure"; exit 1; fi
	@if ! grep -q "Test passed" sim.log; then echo "Simulation did not complete"; exit 1; fi

lint:
	verilator --lint-only -Wall --timing --assert --top-module $(TOP) -f sim.f

clean:
	rm -rf obj_dir sim.log

.PHONY: all run lint clean
